// File: hdl/fdma_config.svh
`ifndef FDMA_CONFIG_SVH
`define FDMA_CONFIG_SVH

// datapath geometry
`define FDMA_ADDR_W      32      // byte address
`define FDMA_DATA_W      64
`define FDMA_BYTES       8       // bytes per beat
`define FDMA_SIZE_W      16      // command size in beats

// burst limit, INCR bursts never exceed this
`define FDMA_MAX_BURST   16

// fixed AXI fields
`define FDMA_ID_W        3
`define FDMA_AXI_ID      0
`define FDMA_AXI_SIZE    3       // log2 of FDMA_BYTES
`define FDMA_AXI_BURST   2'b01   // INCR
`define FDMA_AXI_CACHE   4'b0010 // normal non-cacheable, non-bufferable

`endif

// File: hdl/fdma_pkg.sv
`include "fdma_config.svh"

package fdma_pkg;

    // user command, one per transfer
    typedef struct packed {
        logic [`FDMA_ADDR_W-1:0] addr;  // start byte address, beat aligned
        logic [`FDMA_SIZE_W-1:0] size;  // beats, at least 1
    } fdma_cmd_t;

    // one planned burst, engine to port
    typedef struct packed {
        logic [`FDMA_ADDR_W-1:0] addr;
        logic [7:0]              len;   // beats minus one
    } fdma_burst_t;

    // AW and AR share the same payload
    typedef struct packed {
        logic [`FDMA_ID_W-1:0]   id;
        logic [`FDMA_ADDR_W-1:0] addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
        logic [3:0]              cache;
    } axi_ax_t;

    typedef struct packed {
        logic [`FDMA_DATA_W-1:0]   data;
        logic [`FDMA_DATA_W/8-1:0] strb;
        logic                      last;
    } axi_w_t;

    typedef struct packed {
        logic [`FDMA_DATA_W-1:0] data;
        logic [1:0]              resp;  // not checked
        logic                    last;  // not trusted, beats are counted
    } axi_r_t;

endpackage

// File: hdl/fdma_burst_engine.sv
`timescale 1ns/100ps
`include "fdma_config.svh"

module fdma_burst_engine import fdma_pkg::*; (
    input  logic        M_AXI_ACLK,
    input  logic        fdma_rstart,
    // user command side
    input  logic        req,
    input  fdma_cmd_t   cmd,
    output logic        busy,
    // port side
    output fdma_burst_t burst,
    output logic        burst_valid,
    input  logic        burst_ready,
    input  logic        burst_done
);

    logic                    accept;       // new command taken this cycle
    logic [`FDMA_SIZE_W-1:0] remain;       // beats not yet completed
    logic [8:0]              beats;        // beats in the current burst
    logic [`FDMA_SIZE_W-1:0] remain_next;  // after current burst completes
    logic                    last_burst;
    logic [`FDMA_ADDR_W-1:0] addr_step;    // bytes covered by current burst

    // smaller of left and max burst, as AXI len
    function automatic logic [7:0] plan_len(input logic [`FDMA_SIZE_W-1:0] left);
        logic [`FDMA_SIZE_W-1:0] n;
        begin
            if (left > `FDMA_SIZE_W'(`FDMA_MAX_BURST))
                n = `FDMA_SIZE_W'(`FDMA_MAX_BURST);
            else
                n = left;
            return 8'(n - 1'b1);
        end
    endfunction

    assign accept      = req & ~busy;  // requests while busy are dropped
    assign beats       = {1'b0, burst.len} + 9'd1;
    assign remain_next = remain - `FDMA_SIZE_W'(beats);
    assign last_burst  = (remain_next == '0);
    assign addr_step   = `FDMA_ADDR_W'(beats) * `FDMA_ADDR_W'(`FDMA_BYTES);

    // command lock and burst offer
    always_ff @(posedge M_AXI_ACLK) begin
        if (fdma_rstart) begin
            busy        <= 1'b0;
            burst_valid <= 1'b0;
        end else begin
            if (accept) begin
                busy        <= 1'b1;
                burst_valid <= 1'b1;  // first burst offered next cycle
            end else if (burst_done) begin
                // either release the lock or offer the next burst
                busy        <= ~last_burst;
                burst_valid <= ~last_burst;
            end else if (burst_valid && burst_ready) begin
                burst_valid <= 1'b0;  // port owns it now
            end
        end
    end

    // address and remaining beat tracking
    always_ff @(posedge M_AXI_ACLK) begin
        if (accept) begin
            burst.addr <= cmd.addr;
            burst.len  <= plan_len(cmd.size);
            remain     <= cmd.size;
        end else if (burst_done) begin
            burst.addr <= burst.addr + addr_step;  // next burst follows on
            burst.len  <= plan_len(remain_next);   // don't care on last burst
            remain     <= remain_next;
        end
    end

endmodule

// File: hdl/fdma_wr_port.sv
`timescale 1ns/100ps
`include "fdma_config.svh"

module fdma_wr_port import fdma_pkg::*; (
    input  logic                    M_AXI_ACLK,
    input  logic                    fdma_rstart,
    input  fdma_burst_t             burst,
    input  logic                    burst_valid,
    output logic                    burst_ready,
    output logic                    burst_done,
    output axi_ax_t                 aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_w_t                  w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready,
    input  logic [`FDMA_DATA_W-1:0] wr_data,
    input  logic                    wr_data_ready,
    output logic                    wr_data_taken
);

    fdma_burst_t cur;      // burst in flight
    logic        active;   // W beats still owed
    logic        b_wait;   // write response outstanding
    logic [7:0]  cnt;      // W beats done in this burst
    logic        w_next;

    assign burst_ready = ~active & ~awvalid & ~b_wait;
    assign w_next      = wvalid & wready;
    assign burst_done  = w_next & w.last;

    always_ff @(posedge M_AXI_ACLK) begin
        if (fdma_rstart) begin
            active  <= 1'b0;
            awvalid <= 1'b0;
            b_wait  <= 1'b0;
        end else begin
            if (burst_valid && burst_ready) begin
                active  <= 1'b1;
                awvalid <= 1'b1;
            end else begin
                if (awvalid && awready)
                    awvalid <= 1'b0;  // payload held until here
                if (burst_done)
                    active <= 1'b0;
            end
            if (burst_done)
                b_wait <= 1'b1;
            else if (bvalid)
                b_wait <= 1'b0;  // resp value ignored
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (burst_valid && burst_ready) begin
            cur <= burst;
            cnt <= '0;
        end else if (w_next) begin
            cnt <= cnt + 8'd1;
        end
    end

    assign aw = '{id:    `FDMA_ID_W'(`FDMA_AXI_ID),
                  addr:  cur.addr,
                  len:   cur.len,
                  size:  3'(`FDMA_AXI_SIZE),
                  burst: `FDMA_AXI_BURST,
                  cache: `FDMA_AXI_CACHE};

    assign wvalid        = active & wr_data_ready;  // user gates the W channel
    assign w.data        = wr_data;
    assign w.strb        = '1;                      // full beats only
    assign w.last        = (cnt == cur.len) & wvalid;
    assign bready        = 1'b1;
    assign wr_data_taken = w_next;                  // user advances its data

endmodule

// File: hdl/fdma_rd_port.sv
`timescale 1ns/100ps
`include "fdma_config.svh"

module fdma_rd_port import fdma_pkg::*; (
    input  logic                    M_AXI_ACLK,
    input  logic                    fdma_rstart,
    input  fdma_burst_t             burst,
    input  logic                    burst_valid,
    output logic                    burst_ready,
    output logic                    burst_done,
    output axi_ax_t                 ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_r_t                  r,
    input  logic                    rvalid,
    output logic                    rready,
    output logic [`FDMA_DATA_W-1:0] rd_data,
    input  logic                    rd_data_ready,
    output logic                    rd_data_valid
);

    fdma_burst_t cur;
    logic        active;  // R beats still expected
    logic [7:0]  cnt;     // beats accepted so far
    logic        r_next;

    assign burst_ready = ~active & ~arvalid;
    assign rready      = active & rd_data_ready;
    assign r_next      = rvalid & rready;
    assign burst_done  = r_next & (cnt == cur.len);  // own count, not RLAST

    always_ff @(posedge M_AXI_ACLK) begin
        if (fdma_rstart) begin
            active  <= 1'b0;
            arvalid <= 1'b0;
        end else if (burst_valid && burst_ready) begin
            active  <= 1'b1;
            arvalid <= 1'b1;
        end else begin
            if (arvalid && arready)
                arvalid <= 1'b0;
            if (burst_done)
                active <= 1'b0;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (burst_valid && burst_ready) begin
            cur <= burst;
            cnt <= '0;
        end else if (r_next) begin
            cnt <= cnt + 8'd1;
        end
    end

    assign ar = '{id:    `FDMA_ID_W'(`FDMA_AXI_ID),
                  addr:  cur.addr,
                  len:   cur.len,
                  size:  3'(`FDMA_AXI_SIZE),
                  burst: `FDMA_AXI_BURST,
                  cache: `FDMA_AXI_CACHE};

    assign rd_data       = r.data;  // straight through
    assign rd_data_valid = r_next;  // one pulse per accepted beat

endmodule

// File: hdl/fdma_top.sv
`timescale 1ns/100ps
`include "fdma_config.svh"

module fdma_top import fdma_pkg::*; (
    input  logic                    M_AXI_ACLK,
    input  logic                    fdma_rstart,
    // user write side
    input  fdma_cmd_t               wr_cmd,
    input  logic                    wr_req,
    output logic                    wr_busy,
    input  logic [`FDMA_DATA_W-1:0] wr_data,
    input  logic                    wr_data_ready,
    output logic                    wr_data_taken,
    // user read side
    input  fdma_cmd_t               rd_cmd,
    input  logic                    rd_req,
    output logic                    rd_busy,
    output logic [`FDMA_DATA_W-1:0] rd_data,
    input  logic                    rd_data_ready,
    output logic                    rd_data_valid,
    // AXI write
    output axi_ax_t                 aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_w_t                  w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready,
    // AXI read
    output axi_ax_t                 ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_r_t                  r,
    input  logic                    rvalid,
    output logic                    rready
);

    // index 0 write, index 1 read
    fdma_cmd_t   cmd_d         [2];
    logic        req_d         [2];
    logic        busy_d        [2];
    fdma_burst_t burst_d       [2];
    logic        burst_valid_d [2];
    logic        burst_ready_d [2];
    logic        burst_done_d  [2];

    assign cmd_d[0] = wr_cmd;
    assign cmd_d[1] = rd_cmd;
    assign req_d[0] = wr_req;
    assign req_d[1] = rd_req;
    assign wr_busy  = busy_d[0];
    assign rd_busy  = busy_d[1];

    for (genvar d = 0; d < 2; d++) begin : g_dir
        fdma_burst_engine u_engine (
            .M_AXI_ACLK  (M_AXI_ACLK),
            .fdma_rstart (fdma_rstart),
            .req         (req_d[d]),
            .cmd         (cmd_d[d]),
            .busy        (busy_d[d]),
            .burst       (burst_d[d]),
            .burst_valid (burst_valid_d[d]),
            .burst_ready (burst_ready_d[d]),
            .burst_done  (burst_done_d[d])
        );
    end

    fdma_wr_port u_wr_port (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .fdma_rstart   (fdma_rstart),
        .burst         (burst_d[0]),
        .burst_valid   (burst_valid_d[0]),
        .burst_ready   (burst_ready_d[0]),
        .burst_done    (burst_done_d[0]),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .bvalid        (bvalid),
        .bready        (bready),
        .wr_data       (wr_data),
        .wr_data_ready (wr_data_ready),
        .wr_data_taken (wr_data_taken)
    );

    fdma_rd_port u_rd_port (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .fdma_rstart   (fdma_rstart),
        .burst         (burst_d[1]),
        .burst_valid   (burst_valid_d[1]),
        .burst_ready   (burst_ready_d[1]),
        .burst_done    (burst_done_d[1]),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .rd_data       (rd_data),
        .rd_data_ready (rd_data_ready),
        .rd_data_valid (rd_data_valid)
    );

endmodule

// File: verification/fdma_props.sv
`timescale 1ns/100ps

module fdma_props import fdma_pkg::*; (
    input logic    M_AXI_ACLK,
    input logic    fdma_rstart,
    input axi_ax_t aw,
    input logic    awvalid,
    input logic    awready,
    input axi_ax_t ar,
    input logic    arvalid,
    input logic    arready,
    input axi_w_t  w,
    input logic    wvalid,
    input logic    wready,
    input logic    wr_busy,
    input logic    rd_busy
);

    int unsigned fail_count = 0;  // failed assertions so far
    logic [7:0]  w_beats;         // W handshakes since the last WLAST

    always_ff @(posedge M_AXI_ACLK) begin
        if (fdma_rstart)
            w_beats <= '0;
        else if (wvalid && wready)
            w_beats <= w.last ? 8'd0 : w_beats + 8'd1;
    end

    // address channels hold until accepted
    aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (fdma_rstart)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            $error("awvalid dropped or aw payload changed before awready");
            fail_count++;
        end

    ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (fdma_rstart)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("arvalid dropped or ar payload changed before arready");
            fail_count++;
        end

    // WLAST only with WVALID and only on the beat that ends the AW burst
    wlast_valid: assert property (@(posedge M_AXI_ACLK) disable iff (fdma_rstart)
        w.last |-> wvalid && w_beats == aw.len)
        else begin
            $error("wlast seen without wvalid or off the final beat of the burst");
            fail_count++;
        end

    busy_after_reset: assert property (@(posedge M_AXI_ACLK)
        fdma_rstart |=> !wr_busy && !rd_busy)
        else begin
            $error("busy high in the cycle after reset");
            fail_count++;
        end

endmodule

bind fdma_top fdma_props u_props (.*);

// File: verification/tb_fdma.sv
`timescale 1ns/100ps
`include "fdma_config.svh"

module tb_fdma import fdma_pkg::*; ();

    localparam int N_CMDS = 60;
    localparam int MEM_W  = 1024;  // slave memory depth in beats

    logic                    M_AXI_ACLK = 1'b0;
    logic                    fdma_rstart;
    fdma_cmd_t               wr_cmd;
    fdma_cmd_t               rd_cmd;
    logic                    wr_req, wr_busy, wr_data_ready, wr_data_taken;
    logic                    rd_req, rd_busy, rd_data_ready, rd_data_valid;
    logic [`FDMA_DATA_W-1:0] wr_data;
    logic [`FDMA_DATA_W-1:0] rd_data;
    axi_ax_t                 aw;
    axi_ax_t                 ar;
    axi_w_t                  w;
    axi_r_t                  r;
    logic                    awvalid, awready, wvalid, wready, bvalid, bready;
    logic                    arvalid, arready, rvalid, rready;

    integer                  seed = 32'h0c2ba911;
    logic [`FDMA_DATA_W-1:0] slave_mem [MEM_W];  // what the DUT wrote
    logic [`FDMA_DATA_W-1:0] ref_mem   [MEM_W];  // expected content
    logic [`FDMA_DATA_W-1:0] wr_words  [$];      // user data of the current write
    fdma_cmd_t               cur_cmd;
    logic                    is_rd;              // direction of current command
    int                      beats_done;         // user beats so far
    int                      burst_sum;          // beats announced by address phases
    logic [`FDMA_ADDR_W-1:0] w_addr, r_addr;     // slave burst pointers
    int                      w_left, r_left;
    logic                    b_due;              // write response owed
    int                      data_errs, burst_errs, busy_errs;

    fdma_top u_dut (.*);

    function automatic int beat_index(input logic [`FDMA_ADDR_W-1:0] a);
        return int'((a / `FDMA_BYTES) % MEM_W);
    endfunction

    // initial content unique to every beat address
    function automatic logic [`FDMA_DATA_W-1:0] fill_word(input int i);
        return {32'(i) * 32'h9e3779b1, ~32'(i) ^ 32'h3c00_0000};
    endfunction

    function automatic logic dir_busy();
        return is_rd ? rd_busy : wr_busy;
    endfunction

    task automatic show_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] got);
        $display("ERR %0t %s expected %0h got %0h", $time, sig, exp, got);
    endtask

    always #5 M_AXI_ACLK = ~M_AXI_ACLK;

    initial begin  // watchdog
        repeat (10 + N_CMDS * 40 * 4) @(posedge M_AXI_ACLK);
        $display("timeout: commands did not complete within the cycle budget");
        $display("TEST FAIL");
        $finish;
    end

    // address phase seen by the slave
    task automatic check_burst(input axi_ax_t ax, input logic rd);
        logic [`FDMA_ADDR_W-1:0] exp_addr;
        logic [`FDMA_ID_W+8:0]   exp_fixed;  // id size burst cache
        exp_addr  = cur_cmd.addr + `FDMA_ADDR_W'(burst_sum * `FDMA_BYTES);
        exp_fixed = {`FDMA_ID_W'(0), 3'($clog2(`FDMA_BYTES)), 2'b01, 4'b0010};
        if (rd != is_rd) begin
            burst_errs++;
            $display("address phase at %0t on a direction with no command", $time);
        end
        if (ax.len > 8'(`FDMA_MAX_BURST - 1)) begin
            burst_errs++;
            $display("ERR %0t %s.len expected at most %0d got %0d", $time,
                     rd ? "ar" : "aw", `FDMA_MAX_BURST - 1, ax.len);
        end
        if (ax.addr !== exp_addr) begin
            burst_errs++;
            show_mismatch(rd ? "ar.addr" : "aw.addr", exp_addr, ax.addr);
        end
        if ({ax.id, ax.size, ax.burst, ax.cache} !== exp_fixed) begin
            burst_errs++;
            show_mismatch(rd ? "ar.id/size/burst/cache" : "aw.id/size/burst/cache",
                          64'(exp_fixed), 64'({ax.id, ax.size, ax.burst, ax.cache}));
        end
        burst_sum += ax.len + 1;
        if (rd) begin
            r_addr = ax.addr;
            r_left = ax.len + 1;
        end else begin
            w_addr = ax.addr;
            w_left = ax.len + 1;
        end
    endtask

    // AXI slave and user data side driven on each falling edge
    always @(negedge M_AXI_ACLK) begin
        awready       = ($random(seed) & 3) != 0;  // 3 in 4 ready
        arready       = ($random(seed) & 3) != 0;
        wready        = (w_left > 0) && (($random(seed) & 3) != 0);  // W after AW only
        rvalid        = (r_left > 0) && (($random(seed) & 3) != 0);
        r.data        = slave_mem[beat_index(r_addr)];
        r.resp        = 2'b00;
        r.last        = (r_left == 1);
        bvalid        = b_due;
        b_due         = 1'b0;
        wr_data_ready = ($random(seed) & 3) != 0;
        wr_data       = (beats_done < wr_words.size()) ? wr_words[beats_done] : '0;
        rd_data_ready = ($random(seed) & 3) != 0;
        #1;  // outputs settled so these handshakes complete on the next rising edge
        if (awvalid && awready)
            check_burst(aw, 1'b0);
        if (arvalid && arready)
            check_burst(ar, 1'b1);
        if (bvalid && bready !== 1'b1) begin
            burst_errs++;
            show_mismatch("bready", 64'd1, 64'(bready));
        end
        if (wvalid && wready) begin
            if (w.strb !== {`FDMA_BYTES{1'b1}}) begin
                data_errs++;
                show_mismatch("w.strb", {`FDMA_BYTES{1'b1}}, w.strb);
            end
            slave_mem[beat_index(w_addr)] = w.data;
            w_addr += `FDMA_BYTES;
            w_left--;
            b_due = (w_left == 0);
        end
        if (rvalid && rready) begin
            r_addr += `FDMA_BYTES;
            r_left--;
        end
        if (wr_data_taken) begin
            if (is_rd || beats_done >= int'(cur_cmd.size)) begin
                busy_errs++;
                $display("write beat taken at %0t outside a write command", $time);
            end
            beats_done++;
        end
        if (rd_data_valid) begin
            if (!is_rd || beats_done >= int'(cur_cmd.size)) begin
                busy_errs++;
                $display("read beat delivered at %0t outside a read command", $time);
            end else if (rd_data !== ref_mem[beat_index(cur_cmd.addr) + beats_done]) begin
                data_errs++;
                show_mismatch("rd_data", ref_mem[beat_index(cur_cmd.addr) + beats_done],
                              rd_data);
            end
            beats_done++;
        end
    end

    // one command from request to falling busy
    task automatic run_command();
        int        size;
        int        base;
        fdma_cmd_t stray;
        size         = 1 + int'($unsigned($random(seed)) % 40);
        base         = int'($unsigned($random(seed)) % (MEM_W - 40));
        cur_cmd.addr = `FDMA_ADDR_W'(base * `FDMA_BYTES);  // beat aligned
        cur_cmd.size = `FDMA_SIZE_W'(size);
        is_rd        = ($random(seed) & 1) != 0;
        beats_done   = 0;
        burst_sum    = 0;
        wr_words.delete();
        if (!is_rd) begin
            for (int i = 0; i < size; i++) begin
                wr_words.push_back({$random(seed), $random(seed)});
                ref_mem[base + i] = wr_words[i];
            end
        end
        @(negedge M_AXI_ACLK);
        if (is_rd) begin
            rd_cmd = cur_cmd;
            rd_req = 1'b1;
        end else begin
            wr_cmd = cur_cmd;
            wr_req = 1'b1;
        end
        @(negedge M_AXI_ACLK);
        wr_req = 1'b0;
        rd_req = 1'b0;
        if (dir_busy() !== 1'b1) begin
            busy_errs++;
            $display("busy did not rise after the request at %0t", $time);
        end
        @(negedge M_AXI_ACLK);
        if (dir_busy()) begin  // must be dropped by the DUT
            stray.addr = `FDMA_ADDR_W'(($unsigned($random(seed)) % 512) * `FDMA_BYTES);
            stray.size = 16'd7;
            if (is_rd) begin
                rd_cmd = stray;
                rd_req = 1'b1;
            end else begin
                wr_cmd = stray;
                wr_req = 1'b1;
            end
            @(negedge M_AXI_ACLK);
            wr_req = 1'b0;
            rd_req = 1'b0;
        end
        while (dir_busy())
            @(negedge M_AXI_ACLK);
        if (beats_done != size) begin
            busy_errs++;
            show_mismatch(is_rd ? "rd beats" : "wr beats", 64'(size), 64'(beats_done));
        end
        if (burst_sum != size) begin
            burst_errs++;
            show_mismatch("burst beat sum", 64'(size), 64'(burst_sum));
        end
        if (!is_rd) begin
            for (int i = 0; i < size; i++) begin
                if (slave_mem[base + i] !== wr_words[i]) begin
                    data_errs++;
                    show_mismatch($sformatf("mem[%0d]", base + i), wr_words[i],
                                  slave_mem[base + i]);
                end
            end
        end
    endtask

    initial begin
        fdma_rstart   = 1'b1;
        wr_cmd        = '0;
        rd_cmd        = '0;
        wr_req        = 1'b0;
        rd_req        = 1'b0;
        wr_data       = '0;
        wr_data_ready = 1'b0;
        rd_data_ready = 1'b0;
        awready       = 1'b0;
        wready        = 1'b0;
        bvalid        = 1'b0;
        arready       = 1'b0;
        rvalid        = 1'b0;
        r             = '0;
        cur_cmd       = '0;
        is_rd         = 1'b0;
        beats_done    = 0;
        burst_sum     = 0;
        w_addr        = '0;
        r_addr        = '0;
        w_left        = 0;
        r_left        = 0;
        b_due         = 1'b0;
        data_errs     = 0;
        burst_errs    = 0;
        busy_errs     = 0;
        for (int i = 0; i < MEM_W; i++) begin
            slave_mem[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end
        repeat (10) @(negedge M_AXI_ACLK);  // reset for 10 cycles
        fdma_rstart = 1'b0;
        for (int n = 0; n < N_CMDS; n++)
            run_command();
        $display("errors: data %0d, burst %0d, busy %0d, assertions %0d",
                 data_errs, burst_errs, busy_errs, u_dut.u_props.fail_count);
        if (data_errs + burst_errs + busy_errs + u_dut.u_props.fail_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: all.f
+incdir+hdl
hdl/fdma_pkg.sv
hdl/fdma_burst_engine.sv
hdl/fdma_wr_port.sv
hdl/fdma_rd_port.sv
hdl/fdma_top.sv
verification/fdma_props.sv
verification/tb_fdma.sv

// File: run.sh
#!/bin/sh
# build and run the fdma testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_fdma -f all.f

# keep running after an assertion error so the testbench can report it
./obj_dir/Vtb_fdma +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
